// File: source/mon_pkg.sv
package mon_pkg;

  // Sensor channels in sweep order
  typedef enum logic [1:0] {
    CH_TEMP   = 2'd0,  // Internal temperature
    CH_VCCINT = 2'd1,  // Core supply
    CH_VCCAUX = 2'd2,  // Auxiliary supply
    CH_VBRAM  = 2'd3   // Block-RAM supply
  } chan_e;

  // Poller FSM states
  typedef enum logic [1:0] {
    IDLE  = 2'd0,  // Waiting for the update timer
    ISSUE = 2'd1,  // den high for one cycle
    WAIT  = 2'd2   // Read outstanding, waiting on drdy
  } poll_state_e;

  // DRP status register addresses
  localparam logic [6:0] ADDR_TEMP   = 7'h00;
  localparam logic [6:0] ADDR_VCCINT = 7'h01;
  localparam logic [6:0] ADDR_VCCAUX = 7'h02;
  localparam logic [6:0] ADDR_VBRAM  = 7'h06;

  // Cycles from den to drdy in the sensor bank
  localparam int DRP_LATENCY = 2;

  // Clocks between sweep starts
  localparam int UPDATE_PERIOD = 64;
  localparam int UPD_CNT_W     = $clog2(UPDATE_PERIOD);

  // Over-temperature thresholds on the 16-bit left-justified result
  localparam logic [15:0] OT_SET   = 16'hC000;  // Set at or above
  localparam logic [15:0] OT_CLEAR = 16'hB000;  // Clear below

  // Address table lookup, channel to DRP address
  function automatic logic [6:0] chan_addr(chan_e ch);
    logic [6:0] addr;
    case (ch)
      CH_TEMP:   addr = ADDR_TEMP;
      CH_VCCINT: addr = ADDR_VCCINT;
      CH_VCCAUX: addr = ADDR_VCCAUX;
      CH_VBRAM:  addr = ADDR_VBRAM;
      default:   addr = ADDR_TEMP;
    endcase
    return addr;
  endfunction

endpackage

// File: source/drp_poller.sv
`timescale 1ns/1ps

module drp_poller (
  input  logic        clk,
  input  logic        rst,
  input  logic        drdy,        // Read data ready from the bank
  input  logic [15:0] dout,        // Read data from the bank
  output logic        den,         // One-cycle read enable
  output logic [6:0]  daddr,       // Held from den until drdy
  output logic [15:0] temp_out,
  output logic [15:0] vccint_out,
  output logic [15:0] vccaux_out,
  output logic [15:0] vbram_out,
  output logic        read,        // Pulse per channel read
  output logic        temp_valid,  // New temperature result
  output logic        sweep_done   // All four results updated
);
  import mon_pkg::*;

  logic [UPD_CNT_W-1:0] upd_cnt;   // Update timer
  logic                 upd_wrap;  // Timer at its last count
  poll_state_e          state;
  logic [1:0]           chan_idx;  // Channel being read
  logic                 capture;   // Result accepted this cycle

  assign upd_wrap = (upd_cnt == UPD_CNT_W'(UPDATE_PERIOD - 1));
  assign capture  = (state == WAIT) && drdy;

  // Free-running timer, 0 to UPDATE_PERIOD-1
  always_ff @(posedge clk) begin
    if (rst) begin
      upd_cnt <= '0;
    end else if (upd_wrap) begin
      upd_cnt <= '0;
    end else begin
      upd_cnt <= upd_cnt + 1'b1;
    end
  end

  // Sweep FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      chan_idx <= 2'd0;
    end else begin
      case (state)
        IDLE: begin
          if (upd_wrap) begin  // Start a sweep at the timer wrap
            state    <= ISSUE;
            chan_idx <= 2'd0;  // Always begin with temperature
          end
        end
        ISSUE: state <= WAIT;  // den goes out this cycle
        WAIT: begin
          if (drdy) begin
            chan_idx <= chan_idx + 2'd1;
            // Last channel ends the sweep
            state <= (chan_idx == 2'd3) ? IDLE : ISSUE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // DRP request side
  assign den   = (state == ISSUE);
  assign read  = den;
  assign daddr = chan_addr(chan_e'(chan_idx));  // Stable until the index steps

  // Result registers, selected by the channel index
  always_ff @(posedge clk) begin
    if (rst) begin
      temp_out   <= 16'h0000;
      vccint_out <= 16'h0000;
      vccaux_out <= 16'h0000;
      vbram_out  <= 16'h0000;
    end else if (capture) begin
      case (chan_idx)
        2'd0:    temp_out   <= dout;
        2'd1:    vccint_out <= dout;
        2'd2:    vccaux_out <= dout;
        default: vbram_out  <= dout;
      endcase
    end
  end

  // Status pulses, high while the new result is already on the output
  always_ff @(posedge clk) begin
    if (rst) begin
      temp_valid <= 1'b0;
      sweep_done <= 1'b0;
    end else begin
      temp_valid <= capture && (chan_idx == 2'd0);
      sweep_done <= capture && (chan_idx == 2'd3);
    end
  end

endmodule

// File: source/sensor_bank.sv
`timescale 1ns/1ps

module sensor_bank (
  input  logic            clk,
  input  logic            rst,
  input  logic            sample_valid,  // Conversion sample strobe
  input  mon_pkg::chan_e  sample_chan,   // Channel of the sample
  input  logic [11:0]     sample_code,   // Raw 12-bit ADC code
  input  logic            den,           // DRP read enable
  input  logic [6:0]      daddr,         // DRP address
  output logic            drdy,          // Read data ready
  output logic [15:0]     dout           // Read data
);
  import mon_pkg::*;

  logic [15:0] status_reg [4];             // One per channel, indexed by chan_e
  logic [15:0] rd_decode;                  // Register picked by daddr
  logic [DRP_LATENCY-1:0] rd_vld;          // Read-valid pipeline
  logic [15:0] rd_data [DRP_LATENCY];      // Read-data pipeline

  // Status registers take the code left-justified
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        status_reg[i] <= 16'h0000;
      end
    end else if (sample_valid) begin
      status_reg[sample_chan] <= {sample_code, 4'h0};
    end
  end

  // Address decode against the current register contents
  always_comb begin
    case (daddr)
      ADDR_TEMP:   rd_decode = status_reg[CH_TEMP];
      ADDR_VCCINT: rd_decode = status_reg[CH_VCCINT];
      ADDR_VCCAUX: rd_decode = status_reg[CH_VCCAUX];
      ADDR_VBRAM:  rd_decode = status_reg[CH_VBRAM];
      default:     rd_decode = 16'h0000;  // Unmapped address reads zero
    endcase
  end

  // Valid bits shift one stage per clock
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= '0;
    end else begin
      rd_vld[0] <= den;
      for (int i = 1; i < DRP_LATENCY; i++) begin
        rd_vld[i] <= rd_vld[i-1];
      end
    end
  end

  // Data is captured at the den edge
  // A same-edge sample write lands after this read
  always_ff @(posedge clk) begin
    rd_data[0] <= rd_decode;
    for (int i = 1; i < DRP_LATENCY; i++) begin
      rd_data[i] <= rd_data[i-1];
    end
  end

  assign drdy = rd_vld[DRP_LATENCY-1];   // DRP_LATENCY cycles after den
  assign dout = rd_data[DRP_LATENCY-1];

endmodule

// File: source/ot_alarm.sv
`timescale 1ns/1ps

module ot_alarm (
  input  logic        clk,
  input  logic        rst,
  input  logic        temp_valid,  // Pulse with each new temperature result
  input  logic [15:0] temp_out,    // Latest temperature result
  output logic        otemp        // Over-temperature alarm level
);
  import mon_pkg::*;

  logic above_set;    // Result at or above the set threshold
  logic below_clear;  // Result under the clear threshold

  // Threshold compares on the left-justified result
  assign above_set   = (temp_out >= OT_SET);
  assign below_clear = (temp_out <  OT_CLEAR);

  // Hysteresis flag
  // Only a fresh result may move it, so a stale
  // reading held on temp_out never toggles the alarm
  always_ff @(posedge clk) begin
    if (rst) begin
      otemp <= 1'b0;
    end else if (temp_valid) begin
      if (above_set) begin
        otemp <= 1'b1;       // Hot
      end else if (below_clear) begin
        otemp <= 1'b0;       // Cooled off
      end
      // Between thresholds, hold
    end
  end

endmodule

// File: source/sys_monitor.sv
`timescale 1ns/1ps

module sys_monitor (
  input  logic            clk,
  input  logic            rst,
  input  logic            sample_valid,  // Conversion sample strobe
  input  mon_pkg::chan_e  sample_chan,   // Channel of the sample
  input  logic [11:0]     sample_code,   // 12-bit conversion code
  output logic [15:0]     temp_out,      // Internal temperature
  output logic [15:0]     vccint_out,    // Core supply
  output logic [15:0]     vccaux_out,    // Auxiliary supply
  output logic [15:0]     vbram_out,     // Block-RAM supply
  output logic            read,          // Pulse per channel read
  output logic            sweep_done,    // Sweep finished
  output logic            otemp          // Over-temperature alarm
);

  // DRP port between poller and bank
  logic        den;
  logic [6:0]  daddr;
  logic        drdy;
  logic [15:0] dout;

  logic        temp_valid;  // Poller to alarm

  // Read master and result holder
  drp_poller u_poller (
    .clk        (clk),
    .rst        (rst),
    .drdy       (drdy),
    .dout       (dout),
    .den        (den),
    .daddr      (daddr),
    .temp_out   (temp_out),
    .vccint_out (vccint_out),
    .vccaux_out (vccaux_out),
    .vbram_out  (vbram_out),
    .read       (read),
    .temp_valid (temp_valid),
    .sweep_done (sweep_done)
  );

  // Status register model in place of the ADC
  sensor_bank u_bank (
    .clk          (clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .sample_chan  (sample_chan),
    .sample_code  (sample_code),
    .den          (den),
    .daddr        (daddr),
    .drdy         (drdy),
    .dout         (dout)
  );

  ot_alarm u_alarm (
    .clk        (clk),
    .rst        (rst),
    .temp_valid (temp_valid),
    .temp_out   (temp_out),
    .otemp      (otemp)
  );

endmodule

// File: verif/tb_clk.sv
`timescale 1ns/1ps

module tb_clk (
  output logic clk,
  output logic rst
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset high for the first two rising edges, released just after the second
  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
  end

endmodule

// File: verif/mon_chk.sv
`timescale 1ns/1ps

module mon_chk (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 den,
  input  logic                 drdy,
  input  logic [6:0]           daddr,
  input  logic                 read,
  input  logic                 upd_wrap,  // Timer at its last count
  input  mon_pkg::poll_state_e state
);
  import mon_pkg::*;

  logic pending;    // Read issued and drdy not yet seen
  int   since_den;  // Cycles since the last den
  logic wrapped;    // Timer has wrapped once since reset
  int   fail_cnt = 0;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending   <= 1'b0;
      since_den <= 0;
      wrapped   <= 1'b0;
    end else begin
      if (upd_wrap) wrapped <= 1'b1;
      if (den) begin
        pending   <= 1'b1;
        since_den <= 1;
      end else if (drdy) begin
        pending   <= 1'b0;  // Read answered
        since_den <= 0;
      end else if (pending) begin
        since_den <= since_den + 1;
      end
    end
  end

  a_drdy_latency: assert property (@(posedge clk) disable iff (rst)
    drdy |-> (pending && since_den == DRP_LATENCY))
    else begin
      $error("drdy did not come exactly DRP_LATENCY cycles after den");
      fail_cnt++;
    end

  a_drdy_missing: assert property (@(posedge clk) disable iff (rst)
    pending |-> (since_den <= DRP_LATENCY))
    else begin
      $error("read outstanding longer than DRP_LATENCY cycles");
      fail_cnt++;
    end

  a_addr_stable: assert property (@(posedge clk) disable iff (rst)
    pending |-> $stable(daddr))
    else begin
      $error("daddr changed while a read was outstanding");
      fail_cnt++;
    end

  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    den |-> !pending)
    else begin
      $error("den issued while a read was outstanding");
      fail_cnt++;
    end

  a_wait_state: assert property (@(posedge clk) disable iff (rst)
    pending |-> (state == WAIT))  // FSM must sit in WAIT for the answer
    else begin
      $error("poller left WAIT with a read outstanding");
      fail_cnt++;
    end

  a_quiet_start: assert property (@(posedge clk) disable iff (rst)
    !wrapped |-> !read)
    else begin
      $error("read pulse before the first timer wrap");
      fail_cnt++;
    end

endmodule

// File: verif/mon_checker.sv
`timescale 1ns/1ps

module mon_checker (
  input  logic           clk,
  input  logic           rst,
  input  logic           sample_valid,
  input  mon_pkg::chan_e sample_chan,
  input  logic [11:0]    sample_code,
  input  logic [15:0]    temp_out,
  input  logic [15:0]    vccint_out,
  input  logic [15:0]    vccaux_out,
  input  logic [15:0]    vbram_out,
  input  logic           read,
  input  logic           sweep_done,
  input  logic           otemp,
  output int             err_cnt,  // Mismatches found
  output int             sweeps    // Sweeps compared
);
  import mon_pkg::*;

  // First den to sweep_done, three cycles per read
  localparam int SWEEP_CYCLES = 4 * (DRP_LATENCY + 1);

  logic [15:0] model [4];   // Expected status registers, by channel
  logic [15:0] snap [4];    // Model value taken at each read pulse
  logic        exp_otemp;   // Expected alarm level
  int          rd_idx;      // Reads seen in the current sweep
  int          cyc;         // Cycles since reset release
  int          last_start;  // Cycle of the latest sweep's first read

  // Register contents for a conversion code, left-justified
  function automatic logic [15:0] reg_value(input logic [11:0] code);
    return {code, 4'h0};
  endfunction

  // Alarm after a fresh temperature result
  function automatic logic alarm_next(input logic cur, input logic [15:0] t);
    logic nxt;
    nxt = cur;                      // Hold between the thresholds
    if (t >= OT_SET) nxt = 1'b1;
    else if (t < OT_CLEAR) nxt = 1'b0;
    return nxt;
  endfunction

  task automatic check_value(input string what, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0d ns: %s is 0x%04h, expected 0x%04h",
               $time, what, actual, expected);
      err_cnt++;
    end
  endtask

  // Sampled mid-cycle, away from both the clock edge and the stimulus
  always @(negedge clk) begin
    if (rst) begin
      for (int i = 0; i < 4; i++) begin
        model[i] = 16'h0000;
        snap[i]  = 16'h0000;
      end
      exp_otemp  = 1'b0;
      rd_idx     = 0;
      cyc        = 0;
      last_start = 0;
      err_cnt    = 0;
      sweeps     = 0;
    end else begin
      if (cyc == 0) begin
        check_value("temp_out after reset", temp_out, 16'h0000);
        check_value("vccint_out after reset", vccint_out, 16'h0000);
        check_value("vccaux_out after reset", vccaux_out, 16'h0000);
        check_value("vbram_out after reset", vbram_out, 16'h0000);
        check_value("otemp after reset", {15'd0, otemp}, 16'h0000);
      end
      if (read) begin
        if (rd_idx == 0) begin  // Timer wraps every UPDATE_PERIOD, den one cycle later
          if (cyc != last_start + UPDATE_PERIOD) begin
            $display("[ERROR] %0d ns: sweep started at cycle %0d, expected cycle %0d",
                     $time, cyc, last_start + UPDATE_PERIOD);
            err_cnt++;
          end
          last_start = cyc;
        end
        if (rd_idx < 4) begin
          snap[rd_idx] = model[rd_idx];  // Before this edge's sample write
        end else begin
          $display("[ERROR] %0d ns: more than four reads in one sweep", $time);
          err_cnt++;
        end
        rd_idx++;
      end
      if (sample_valid) model[sample_chan] = reg_value(sample_code);
      if (sweep_done) begin
        if (rd_idx != 4) begin
          $display("[ERROR] %0d ns: sweep_done after %0d reads instead of four",
                   $time, rd_idx);
          err_cnt++;
        end
        if (cyc - last_start != SWEEP_CYCLES) begin
          $display("[ERROR] %0d ns: sweep took %0d cycles, expected %0d",
                   $time, cyc - last_start, SWEEP_CYCLES);
          err_cnt++;
        end
        check_value("temp_out", temp_out, snap[CH_TEMP]);
        check_value("vccint_out", vccint_out, snap[CH_VCCINT]);
        check_value("vccaux_out", vccaux_out, snap[CH_VCCAUX]);
        check_value("vbram_out", vbram_out, snap[CH_VBRAM]);
        exp_otemp = alarm_next(exp_otemp, snap[CH_TEMP]);
        check_value("otemp", {15'd0, otemp}, {15'd0, exp_otemp});
        rd_idx = 0;
        sweeps++;
      end
      cyc++;
    end
  end

endmodule

// File: verif/tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import mon_pkg::*;

  localparam int N_OT_STEPS  = 8;   // Directed temperature codes
  localparam int RAND_SWEEPS = 40;
  // Reset check, threshold steps, same-cycle reads, random run, final flush
  localparam int N_SWEEPS = 1 + N_OT_STEPS + 3 * 4 + RAND_SWEEPS + 1;

  logic        clk;
  logic        rst;
  logic        sample_valid;
  chan_e       sample_chan;
  logic [11:0] sample_code;
  logic [15:0] temp_out;
  logic [15:0] vccint_out;
  logic [15:0] vccaux_out;
  logic [15:0] vbram_out;
  logic        read;
  logic        sweep_done;
  logic        otemp;
  int          err_cnt;
  int          sweeps;
  int          total_err;

  // Temperature codes straddling OT_CLEAR and OT_SET
  logic [11:0] ot_codes [N_OT_STEPS] = '{12'hBFF, 12'hC00, 12'hBFF, 12'hB00,
                                         12'hAFF, 12'hFFF, 12'h000, 12'hB80};

  tb_clk u_clk (
    .clk (clk),
    .rst (rst)
  );

  sys_monitor DUT (
    .clk          (clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .sample_chan  (sample_chan),
    .sample_code  (sample_code),
    .temp_out     (temp_out),
    .vccint_out   (vccint_out),
    .vccaux_out   (vccaux_out),
    .vbram_out    (vbram_out),
    .read         (read),
    .sweep_done   (sweep_done),
    .otemp        (otemp)
  );

  mon_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .sample_valid (sample_valid),
    .sample_chan  (sample_chan),
    .sample_code  (sample_code),
    .temp_out     (temp_out),
    .vccint_out   (vccint_out),
    .vccaux_out   (vccaux_out),
    .vbram_out    (vbram_out),
    .read         (read),
    .sweep_done   (sweep_done),
    .otemp        (otemp),
    .err_cnt      (err_cnt),
    .sweeps       (sweeps)
  );

  // DRP protocol assertions inside the poller
  bind drp_poller mon_chk u_chk (
    .clk      (clk),
    .rst      (rst),
    .den      (den),
    .drdy     (drdy),
    .daddr    (daddr),
    .read     (read),
    .upd_wrap (upd_wrap),
    .state    (state)
  );

  task automatic step();  // 1 ns past the next rising edge
    @(posedge clk);
    #1;
  endtask

  task automatic write_sample(input chan_e ch, input logic [11:0] code);
    sample_valid = 1'b1;
    sample_chan  = ch;
    sample_code  = code;
    step();
    sample_valid = 1'b0;
  endtask

  task automatic wait_sweep();
    step();
    while (!sweep_done) step();
  endtask

  // Write a channel on the very cycle of its own read pulse
  task automatic sample_on_read(input chan_e ch, input logic [11:0] code);
    int  count;
    logic done;
    count = 0;
    done  = 1'b0;
    wait_sweep();
    while (!done) begin
      step();
      if (read) begin
        if (count == int'(ch)) begin
          write_sample(ch, code);
          done = 1'b1;
        end
        count++;
      end
    end
    wait_sweep();  // Still shows the old value
    wait_sweep();  // New value visible here
  endtask

  initial begin
    int target;
    int gap;
    sample_valid = 1'b0;
    sample_chan  = CH_TEMP;
    sample_code  = 12'h000;
    void'($urandom(68));
    @(negedge rst);
    #1;
    wait_sweep();  // First sweep reads all zeros
    for (int i = 0; i < N_OT_STEPS; i++) begin
      write_sample(CH_TEMP, ot_codes[i]);  // Well clear of the next sweep
      wait_sweep();
    end
    sample_on_read(CH_TEMP, 12'h5A5);
    sample_on_read(CH_VCCINT, 12'h3C3);
    sample_on_read(CH_VCCAUX, 12'h812);
    sample_on_read(CH_VBRAM, 12'hE7E);
    target = sweeps + RAND_SWEEPS;
    while (sweeps < target) begin
      gap = int'($urandom_range(0, 9));
      repeat (gap) step();
      write_sample(chan_e'(2'($urandom_range(0, 3))), 12'($urandom_range(0, 4095)));
    end
    wait_sweep();
    repeat (4) step();
    total_err = err_cnt + DUT.u_poller.u_chk.fail_cnt;
    $display("Closing report: %0d sweeps checked, %0d mismatches, %0d assertion failures",
             sweeps, err_cnt, DUT.u_poller.u_chk.fail_cnt);
    if (total_err == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog, a few spare sweep periods past the expected run length
  initial begin
    #((N_SWEEPS + 4) * UPDATE_PERIOD * 10);
    $display("Timeout: run did not finish within %0d update periods", N_SWEEPS + 4);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: flist.f
source/mon_pkg.sv
source/drp_poller.sv
source/sensor_bank.sv
source/ot_alarm.sv
source/sys_monitor.sv
verif/tb_clk.sv
verif/mon_chk.sv
verif/mon_checker.sv
verif/tb_top.sv

// File: Makefile
BIN  := obj_dir/Vtb_top
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: run

$(BIN): flist.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module tb_top -f flist.f -o Vtb_top

run: $(BIN)
	$(BIN) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
